// ==== dv/afifo_patterns.txt ====
// columns: 32-bit write word, then the four bytes the read port returns for it
// bytes are listed in read order, low lane (bits 7:0) first
03020100 00 01 02 03
deadbeef ef be ad de
12345678 78 56 34 12
a5a55a5a 5a 5a a5 a5
0f1e2d3c 3c 2d 1e 0f
ffffffff ff ff ff ff
00000000 00 00 00 00
80402010 10 20 40 80
13579bdf df 9b 57 13
2468ace0 e0 ac 68 24
c0ffee11 11 ee ff c0
7e817e81 81 7e 81 7e
55aa33cc cc 33 aa 55
01234567 67 45 23 01
fedcba98 98 ba dc fe
6b1d9e40 40 9e 1d 6b

// ==== compile.f ====
+incdir+rtl
rtl/afifo_pkg.sv
rtl/cdc_sync.sv
rtl/gray_counter.sv
rtl/afifo_ram.sv
rtl/afifo_ctrl.sv
rtl/afifo_top.sv
dv/afifo_asserts.sv
dv/afifo_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = afifo_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/afifo_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "afifo_settings.svh"

module afifo_tb
   import afifo_pkg::*;
();

   localparam int W_HALF    = 50;
   localparam int R_HALF    = 65;
   localparam int PAT_WORDS = 16;
   localparam int PAT_LINES = PAT_WORDS * 5;
   // words pushed over all tests including the dropped ones
   localparam int WORDS_RUN  = 16 + 20 + 32 + 5;
   localparam int TIMEOUT_NS = (WORDS_RUN * 40 + 100) * 2 * W_HALF;

   logic                       w_clk;
   logic                       r_clk;
   logic                       rst;
   logic                       w_en;
   logic [`AFIFO_W_DATA_W-1:0] w_data;
   logic                       r_en;
   fifo_status_t               w_status;
   fifo_status_t               r_status;
   logic [`AFIFO_R_DATA_W-1:0] r_data;

   logic [31:0] pat_mem [PAT_LINES];
   logic [31:0] lfsr_state;
   int          wr_words;
   int          rd_bytes;
   int          error_count;
   int          errors_before;
   int          tests_run;
   int          tests_failed;
   string       test_name;

   afifo_top UUT (
      .w_clk_i    (w_clk),
      .r_clk_i    (r_clk),
      .rst_i      (rst),
      .w_en_i     (w_en),
      .w_data_i   (w_data),
      .w_status_o (w_status),
      .r_en_i     (r_en),
      .r_status_o (r_status),
      .r_data_o   (r_data)
   );

   bind afifo_ctrl afifo_asserts u_asserts (
      .w_clk_i    (w_clk_i),
      .r_clk_i    (r_clk_i),
      .rst_i      (rst_i),
      .r_rst_i    (r_rst),
      .mem_wr_i   (mem_wr_o),
      .mem_rd_i   (mem_rd_o),
      .w_gray_i   (w_wptr_gray),
      .w_bin_i    (w_wptr_bin),
      .r_gray_i   (r_rptr_gray),
      .r_bin_i    (r_rptr_bin),
      .w_level_i  (w_level),
      .r_level_i  (r_level)
   );

   always #(W_HALF) w_clk = ~w_clk;
   always #(R_HALF) r_clk = ~r_clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      // taps 32 22 2 1
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic [31:0] pattern_word(input int n);
      return pat_mem[(n % PAT_WORDS) * 5];
   endfunction

   // byte m of the stream is lane m%4 of word m/4
   function automatic logic [7:0] expected_byte(input int m);
      return pat_mem[((m / 4) % PAT_WORDS) * 5 + 1 + (m % 4)][7:0];
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
         error_count++;
      end
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      errors_before = error_count;
   endtask

   task automatic end_test();
      tests_run++;
      if (error_count == errors_before) begin
         $display("test %0d %s: ok", tests_run, test_name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAILED with %0d errors", tests_run, test_name,
                  error_count - errors_before);
      end
   endtask

   task automatic write_words(input int count);
      int sent;
      sent = 0;
      while (sent < count) begin
         @(posedge w_clk);
         if (w_en && !w_status.full) begin
            wr_words++;
            sent++;
         end
         if (sent < count) begin
            w_en   <= 1'b1;
            w_data <= pattern_word(wr_words);
         end else begin
            w_en <= 1'b0;
         end
      end
   endtask

   // data shows up one read clock after the accepting edge
   task automatic read_bytes(input int count, input bit stall);
      int         got;
      logic       pend;
      logic [7:0] exp_q;
      logic [1:0] rbits;
      got   = 0;
      pend  = 1'b0;
      exp_q = '0;
      rbits = '0;
      while (got < count || pend) begin
         @(posedge r_clk);
         if (pend) begin
            check_value(32'(r_data), 32'(exp_q), "read byte");
            pend = 1'b0;
         end
         if (r_en && !r_status.empty) begin
            exp_q = expected_byte(rd_bytes);
            rd_bytes++;
            got++;
            pend = 1'b1;
         end
         if (got >= count) begin
            r_en <= 1'b0;
         end else if (stall) begin
            lfsr_state = lfsr_next(lfsr_state);
            rbits[0]   = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            rbits[1]   = lfsr_state[0];
            r_en <= |rbits;
         end else begin
            r_en <= 1'b1;
         end
      end
   endtask

   // pushes into a full fifo that must all be dropped
   task automatic drop_writes(input int count);
      @(posedge w_clk);
      w_en   <= 1'b1;
      w_data <= 32'hbad0_0000;
      for (int i = 0; i < count; i++) begin
         @(posedge w_clk);
         check_value(32'(w_status.full), 32'd1, "write full while overflowing");
         w_data <= 32'hbad0_0001 + 32'(i);
      end
      w_en <= 1'b0;
   endtask

   task automatic hold_empty(input int cycles);
      @(posedge r_clk);
      r_en <= 1'b1;
      repeat (cycles) begin
         @(posedge r_clk);
         check_value(32'(r_status.empty), 32'd1, "read empty after drain");
      end
      r_en <= 1'b0;
   endtask

   // flags follow the byte count once both sides are idle
   task automatic settle_and_check();
      int diff;
      repeat (5) @(posedge r_clk);
      diff = 4 * wr_words - rd_bytes;
      check_value(32'(w_status.level), 32'(diff & 63), "write level");
      check_value(32'(r_status.level), 32'(diff & 63), "read level");
      check_value(32'(w_status.empty), 32'(diff < 4), "write empty");
      check_value(32'(w_status.full), 32'(diff > 60), "write full");
      check_value(32'(r_status.empty), 32'(diff < 1), "read empty");
      check_value(32'(r_status.full), 32'(diff > 63), "read full");
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog: the run did not finish within %0d ns, some handshake hung",
               TIMEOUT_NS);
      $display("Test failures found");
      $finish;
   end

   initial begin
      w_clk        = 1'b0;
      r_clk        = 1'b0;
      rst          = 1'b1;
      w_en         = 1'b0;
      w_data       = '0;
      r_en         = 1'b0;
      lfsr_state   = 32'h7bea8030;
      wr_words     = 0;
      rd_bytes     = 0;
      error_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      $readmemh("dv/afifo_patterns.txt", pat_mem);
      if ($isunknown(pat_mem[PAT_LINES-1])) begin
         $display("pattern file dv/afifo_patterns.txt could not be read completely");
         error_count++;
      end

      repeat (3) @(posedge w_clk);
      rst <= 1'b0;

      start_test("reset state");
      settle_and_check();
      end_test();

      start_test("byte order");
      fork
         write_words(PAT_WORDS);
         read_bytes(PAT_WORDS * 4, 1'b0);
      join
      settle_and_check();
      end_test();

      start_test("fill and overflow");
      write_words(PAT_WORDS);
      drop_writes(4);
      settle_and_check();
      read_bytes(PAT_WORDS * 4, 1'b0);
      hold_empty(8);
      settle_and_check();
      end_test();

      start_test("random stalls");
      fork
         write_words(2 * PAT_WORDS);
         read_bytes(2 * PAT_WORDS * 4, 1'b1);
      join
      settle_and_check();
      end_test();

      start_test("settled level");
      write_words(5);
      read_bytes(7, 1'b0);
      settle_and_check();
      read_bytes(10, 1'b0);
      settle_and_check();
      read_bytes(3, 1'b0);
      settle_and_check();
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
               error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/afifo_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "afifo_settings.svh"

module afifo_asserts
   import afifo_pkg::*;
#(
   parameter int R_PTR_W = `AFIFO_ADDR_W + 1,
   parameter int W_PTR_W = R_PTR_W - $clog2(`AFIFO_W_DATA_W / `AFIFO_R_DATA_W)
) (
   input logic               w_clk_i,
   input logic               r_clk_i,
   input logic               rst_i,
   input logic               r_rst_i,
   input mem_wr_t            mem_wr_i,
   input mem_rd_t            mem_rd_i,
   input logic [W_PTR_W-1:0] w_gray_i,
   input logic [W_PTR_W-1:0] w_bin_i,
   input logic [R_PTR_W-1:0] r_gray_i,
   input logic [R_PTR_W-1:0] r_bin_i,
   input logic [R_PTR_W-1:0] w_level_i,
   input logic [R_PTR_W-1:0] r_level_i
);

   localparam int                 PAD_W       = R_PTR_W - W_PTR_W;
   localparam logic [R_PTR_W-1:0] FIFO_BYTES  = {1'b1, {(R_PTR_W-1){1'b0}}};
   localparam int                 W_LEVEL_MAX = (1 << (R_PTR_W - 1)) - (1 << PAD_W);

   // live occupancy taken from both binary pointers at once
   // each side's synchronized view may only be more cautious than this
   logic [R_PTR_W-1:0] live_level;

   assign live_level = {w_bin_i, {PAD_W{1'b0}}} - r_bin_i;

   // read side stays in reset until the re-timed reset drops too
   a_no_write_when_full: assert property (@(posedge w_clk_i) disable iff (rst_i)
      mem_wr_i.en |-> live_level <= W_LEVEL_MAX)
      else $error("write reached the RAM without room for a word");

   a_no_read_when_empty: assert property (@(posedge r_clk_i) disable iff (rst_i || r_rst_i)
      mem_rd_i.en |-> live_level != '0) else $error("read reached the RAM while empty");

   a_w_gray_step: assert property (@(posedge w_clk_i) disable iff (rst_i)
      $countones(w_gray_i ^ $past(w_gray_i)) <= 1) else $error("write gray jumped");

   a_r_gray_step: assert property (@(posedge r_clk_i) disable iff (rst_i || r_rst_i)
      $countones(r_gray_i ^ $past(r_gray_i)) <= 1) else $error("read gray jumped");

   // gray and binary forms of one pointer must agree
   a_w_gray_match: assert property (@(posedge w_clk_i) disable iff (rst_i)
      gray_to_bin({{PAD_W{1'b0}}, w_gray_i}) == {{PAD_W{1'b0}}, w_bin_i})
      else $error("write gray and binary disagree");

   a_r_gray_match: assert property (@(posedge r_clk_i) disable iff (rst_i || r_rst_i)
      gray_to_bin(r_gray_i) == r_bin_i) else $error("read gray and binary disagree");

   a_w_level_max: assert property (@(posedge w_clk_i) disable iff (rst_i)
      w_level_i <= FIFO_BYTES) else $error("write level above capacity");

   a_r_level_max: assert property (@(posedge r_clk_i) disable iff (rst_i || r_rst_i)
      r_level_i <= FIFO_BYTES) else $error("read level above capacity");

endmodule

`default_nettype wire

// ==== rtl/afifo_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "afifo_settings.svh"

module afifo_top
   import afifo_pkg::*;
(
   input  logic                       w_clk_i,
   input  logic                       r_clk_i,
   input  logic                       rst_i,

   // write port
   input  logic                       w_en_i,
   input  logic [`AFIFO_W_DATA_W-1:0] w_data_i,
   output fifo_status_t               w_status_o,

   // read port
   input  logic                       r_en_i,
   output fifo_status_t               r_status_o,
   output logic [`AFIFO_R_DATA_W-1:0] r_data_o
);

   mem_wr_t mem_wr;
   mem_rd_t mem_rd;

   // pointers and flags
   afifo_ctrl u_ctrl (
      .w_clk_i    (w_clk_i),
      .r_clk_i    (r_clk_i),
      .rst_i      (rst_i),
      .w_en_i     (w_en_i),
      .r_en_i     (r_en_i),
      .w_status_o (w_status_o),
      .r_status_o (r_status_o),
      .mem_wr_o   (mem_wr),
      .mem_rd_o   (mem_rd)
   );

   // storage, wide in and narrow out
   afifo_ram u_ram (
      .w_clk_i  (w_clk_i),
      .r_clk_i  (r_clk_i),
      .mem_wr_i (mem_wr),
      .w_data_i (w_data_i),
      .mem_rd_i (mem_rd),
      .r_data_o (r_data_o)
   );

endmodule

`default_nettype wire

// ==== rtl/afifo_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "afifo_settings.svh"

module afifo_ctrl
   import afifo_pkg::*;
(
   input  logic         w_clk_i,
   input  logic         r_clk_i,
   input  logic         rst_i,
   input  logic         w_en_i,
   input  logic         r_en_i,
   output fifo_status_t w_status_o,
   output fifo_status_t r_status_o,
   output mem_wr_t      mem_wr_o,
   output mem_rd_t      mem_rd_o
);

   localparam int ADDR_W    = `AFIFO_ADDR_W;
   localparam int RATIO     = `AFIFO_W_DATA_W / `AFIFO_R_DATA_W;
   localparam int RATIO_LOG = $clog2(RATIO);
   localparam int W_ADDR_W  = ADDR_W - RATIO_LOG;
   localparam int R_ADDR_W  = ADDR_W;

   // all limits are in bytes and one bit wider than the address
   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [ADDR_W:0] W_INCR    = {{(ADDR_W-RATIO_LOG){1'b0}}, 1'b1,
                                            {RATIO_LOG{1'b0}}};
   localparam logic [ADDR_W:0] R_INCR    = {{ADDR_W{1'b0}}, 1'b1};
   localparam logic [ADDR_W:0] W_FULL_LIM = FIFO_SIZE - W_INCR;
   localparam logic [ADDR_W:0] R_FULL_LIM = FIFO_SIZE - R_INCR;

   logic r_rst;

   // own pointers in binary and gray
   logic [W_ADDR_W:0] w_wptr_bin;
   logic [W_ADDR_W:0] w_wptr_gray;
   logic [R_ADDR_W:0] r_rptr_bin;
   logic [R_ADDR_W:0] r_rptr_gray;

   // pointers seen from the other domain
   logic [W_ADDR_W:0] r_wptr_gray;
   logic [R_ADDR_W:0] w_rptr_gray;
   logic [ADDR_W:0]   r_wptr_ext;
   logic [W_ADDR_W:0] r_wptr_bin;
   logic [R_ADDR_W:0] w_rptr_bin;

   // pointers in byte units
   logic [ADDR_W:0] w_wptr_n;
   logic [ADDR_W:0] w_rptr_n;
   logic [ADDR_W:0] r_wptr_n;
   logic [ADDR_W:0] r_rptr_n;

   logic [ADDR_W:0] w_level;
   logic [ADDR_W:0] r_level;
   logic            w_full;
   logic            r_empty;
   logic            w_en_int;
   logic            r_en_int;

   // reset re-timed into the read clock
   cdc_sync #(
      .DATA_W (1)
   ) u_r_rst_sync (
      .clk_i    (r_clk_i),
      .rst_i    (1'b0),
      .signal_i (rst_i),
      .signal_o (r_rst)
   );

   // only accepted operations move the pointers
   assign w_en_int = w_en_i & ~w_full;
   assign r_en_int = r_en_i & ~r_empty;

   gray_counter #(
      .W (W_ADDR_W + 1)
   ) u_w_ptr (
      .clk_i  (w_clk_i),
      .rst_i  (rst_i),
      .en_i   (w_en_int),
      .bin_o  (w_wptr_bin),
      .gray_o (w_wptr_gray)
   );

   gray_counter #(
      .W (R_ADDR_W + 1)
   ) u_r_ptr (
      .clk_i  (r_clk_i),
      .rst_i  (r_rst),
      .en_i   (r_en_int),
      .bin_o  (r_rptr_bin),
      .gray_o (r_rptr_gray)
   );

   // write pointer into read domain
   cdc_sync #(
      .DATA_W (W_ADDR_W + 1)
   ) u_wptr_sync (
      .clk_i    (r_clk_i),
      .rst_i    (r_rst),
      .signal_i (w_wptr_gray),
      .signal_o (r_wptr_gray)
   );

   // read pointer into write domain
   cdc_sync #(
      .DATA_W (R_ADDR_W + 1)
   ) u_rptr_sync (
      .clk_i    (w_clk_i),
      .rst_i    (rst_i),
      .signal_i (r_rptr_gray),
      .signal_o (w_rptr_gray)
   );

   // the narrow write pointer is zero extended before conversion
   assign r_wptr_ext = gray_to_bin({{RATIO_LOG{1'b0}}, r_wptr_gray});
   assign r_wptr_bin = r_wptr_ext[W_ADDR_W:0];
   assign w_rptr_bin = gray_to_bin(w_rptr_gray);

   // scale word pointers to bytes
   assign w_wptr_n = {w_wptr_bin, {RATIO_LOG{1'b0}}};
   assign r_wptr_n = {r_wptr_bin, {RATIO_LOG{1'b0}}};
   assign w_rptr_n = w_rptr_bin;
   assign r_rptr_n = r_rptr_bin;

   // modulo difference stays exact since the level never passes 64
   assign w_level = w_wptr_n - w_rptr_n;
   assign r_level = r_wptr_n - r_rptr_n;

   // full and empty per side use that side's own step size
   assign w_full  = w_level > W_FULL_LIM;
   assign r_empty = r_level < R_INCR;

   assign w_status_o = '{empty: (w_level < W_INCR), full: w_full,
                         level: w_level[ADDR_W-1:0]};
   assign r_status_o = '{empty: r_empty, full: (r_level > R_FULL_LIM),
                         level: r_level[ADDR_W-1:0]};

   // payload joins at the RAM straight from the write port
   assign mem_wr_o = '{en: w_en_int, addr: w_wptr_bin[W_ADDR_W-1:0], data: '0};
   assign mem_rd_o = '{en: r_en_int, addr: r_rptr_bin[R_ADDR_W-1:0]};

endmodule

`default_nettype wire

// ==== rtl/afifo_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "afifo_settings.svh"

module afifo_ram
   import afifo_pkg::*;
(
   input  logic                       w_clk_i,
   input  logic                       r_clk_i,
   input  mem_wr_t                    mem_wr_i,
   input  logic [`AFIFO_W_DATA_W-1:0] w_data_i,
   input  mem_rd_t                    mem_rd_i,
   output logic [`AFIFO_R_DATA_W-1:0] r_data_o
);

   localparam int R_DATA_W   = `AFIFO_R_DATA_W;
   localparam int LANES      = `AFIFO_W_DATA_W / `AFIFO_R_DATA_W;
   localparam int LANE_SEL_W = $clog2(LANES);
   localparam int R_ADDR_W   = `AFIFO_ADDR_W;
   localparam int W_ADDR_W   = R_ADDR_W - LANE_SEL_W;
   localparam int DEPTH      = 1 << W_ADDR_W;

   // byte address splits into word index and lane index
   logic [W_ADDR_W-1:0]   rd_word;
   logic [LANE_SEL_W-1:0] rd_lane;

   logic [R_DATA_W-1:0] lane_rd [LANES];
   logic [R_DATA_W-1:0] r_data_q;

   assign rd_word = mem_rd_i.addr[R_ADDR_W-1:LANE_SEL_W];
   assign rd_lane = mem_rd_i.addr[LANE_SEL_W-1:0];

   // one array per byte lane, lane 0 holds bits 7:0
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [R_DATA_W-1:0] mem [DEPTH];

      // every lane is written together with the whole word
      always_ff @(posedge w_clk_i) begin
         if (mem_wr_i.en) begin
            mem[mem_wr_i.addr] <= w_data_i[l*R_DATA_W +: R_DATA_W];
         end
      end

      assign lane_rd[l] = mem[rd_word];
   end

   // read byte is held until the next accepted read
   always_ff @(posedge r_clk_i) begin
      if (mem_rd_i.en) begin
         r_data_q <= lane_rd[rd_lane];
      end
   end

   assign r_data_o = r_data_q;

endmodule

`default_nettype wire

// ==== rtl/gray_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module gray_counter #(
   parameter int W = 4
) (
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         en_i,
   output logic [W-1:0] bin_o,
   output logic [W-1:0] gray_o
);

   logic [W-1:0] bin_q;
   logic [W-1:0] bin_next;
   logic [W-1:0] gray_q;

   assign bin_next = bin_q + 1'b1;

   // gray is registered from the next binary value so both
   // registers step together and gray_o comes straight off a flop
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_next;
         gray_q <= bin_next ^ (bin_next >> 1);
      end
   end

   // binary kept visible so the owning side needs no conversion
   assign bin_o  = bin_q;
   assign gray_o = gray_q;

endmodule

`default_nettype wire

// ==== rtl/cdc_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module cdc_sync #(
   parameter int DATA_W = 1
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [DATA_W-1:0] signal_i,
   output logic [DATA_W-1:0] signal_o
);

   // first stage may go metastable, second stage settles it
   logic [DATA_W-1:0] meta_q;
   logic [DATA_W-1:0] sync_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= signal_i;
         sync_q <= meta_q;
      end
   end

   // multi-bit use is only safe for gray coded values
   assign signal_o = sync_q;

endmodule

`default_nettype wire

// ==== rtl/afifo_pkg.sv ====
`default_nettype none

`include "afifo_settings.svh"

package afifo_pkg;

   // per-domain view of the fifo, level counted in bytes
   typedef struct packed {
      logic                     empty;
      logic                     full;
      logic [`AFIFO_ADDR_W-1:0] level;
   } fifo_status_t;

   // write request toward the storage array
   typedef struct packed {
      logic                                                     en;
      logic [`AFIFO_ADDR_W-$clog2(`AFIFO_W_DATA_W/`AFIFO_R_DATA_W)-1:0] addr;
      logic [`AFIFO_W_DATA_W-1:0]                               data;
   } mem_wr_t;

   // read request toward the storage array, byte address
   typedef struct packed {
      logic                     en;
      logic [`AFIFO_ADDR_W-1:0] addr;
   } mem_rd_t;

   // gray to binary, sized for the widest pointer
   // narrower pointers are zero extended by the caller
   function automatic logic [`AFIFO_ADDR_W:0] gray_to_bin(
      input logic [`AFIFO_ADDR_W:0] gray
   );
      logic [`AFIFO_ADDR_W:0] bin;
      bin[`AFIFO_ADDR_W] = gray[`AFIFO_ADDR_W];
      for (int i = `AFIFO_ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

// ==== rtl/afifo_settings.svh ====
`ifndef AFIFO_SETTINGS_SVH
`define AFIFO_SETTINGS_SVH

// write port word width in bits
`define AFIFO_W_DATA_W 32

// read port word width in bits
`define AFIFO_R_DATA_W 8

// address width counted in narrow (read) words
// 6 bits gives 64 bytes of storage
`define AFIFO_ADDR_W 6

`endif
